/* sim.f */
hw/m400_pkg.sv
hw/sysbus_if.sv
hw/isk.sv
hw/puks.sv
hw/bus_master.sv
hw/mem_seg.sv
hw/m400_sys.sv
dv/tb_m400_sys.sv

/* Makefile */
# Verilator build and run of the m400 system testbench
TOP = tb_m400_sys

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o sim_$(TOP)

# pass only when the pass message shows up
run: build
	@out=$$(./obj_dir/sim_$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '\*\*\* TEST PASSED \*\*\*'

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/tb_m400_sys.sv */
`timescale 1ns/1ps

module tb_m400_sys;
	import m400_pkg::*;

	localparam int MEM_SEGS    = 2;
	localparam int SEG_WORDS   = 256;
	localparam int NOMEM_TICKS = 16;
	localparam int CLEAR_TICKS = 8;
	localparam int SEED        = 36046;

	// operations per test
	localparam int RAND_N = 200;
	localparam int ARB_N  = 16;
	localparam int MISS_N = 8;
	localparam int CLR_N  = 32;
	localparam int OPS    = 1 + 2 * RAND_N + 2 * ARB_N + 2 * MISS_N + CLR_N;
	// run length bound in cycles
	localparam int LIMIT  = 4 * OPS * 30;

	logic    clk_sys;
	logic    rst_n;
	logic    clear_req;
	logic    pon;
	logic    alarm;
	logic    cpu_req;
	bus_op_e cpu_op;
	nb_t     cpu_nb;
	ad_t     cpu_ad;
	dt_t     cpu_dt;
	logic    cpu_busy;
	logic    cpu_done;
	logic    cpu_err;
	dt_t     cpu_rdata;
	logic    io_req;
	bus_op_e io_op;
	nb_t     io_nb;
	ad_t     io_ad;
	dt_t     io_dt;
	logic    io_busy;
	logic    io_done;
	logic    io_err;
	dt_t     io_rdata;

	// reference memory, keyed by segment and address
	dt_t model [int];
	// keys written so far, targets for reads
	int keys [$];
	int cycle_cnt = 0;

	m400_sys #(
		.MEM_SEGS(MEM_SEGS),
		.SEG_WORDS(SEG_WORDS),
		.NOMEM_TICKS(NOMEM_TICKS),
		.CLEAR_TICKS(CLEAR_TICKS)
	) u_m400_sys (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ----------------------------------------------------------
	// run bound
	// ----------------------------------------------------------

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("timeout: run still going after %0d cycles", LIMIT);
			$display("*** TEST FAILED ***");
			$fatal(1, "run timed out");
		end
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------

	// inputs change 2 ns after the edge, outputs read there too
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	function automatic int key_of(input nb_t nb, input ad_t ad);
		return (int'(nb) << AD_W) | int'(ad);
	endfunction

	// sel 0 cpu ports, sel 1 io ports
	task automatic drive_cmd(input bit sel, input bit req, input bus_op_e op, input nb_t nb,
			input ad_t ad, input dt_t dt);
		if (sel) begin
			io_req = req;
			io_op = op;
			io_nb = nb;
			io_ad = ad;
			io_dt = dt;
		end else begin
			cpu_req = req;
			cpu_op = op;
			cpu_nb = nb;
			cpu_ad = ad;
			cpu_dt = dt;
		end
	endtask

	// write anywhere present, read only known words
	task automatic rand_cmd(output bus_op_e op, output nb_t nb, output ad_t ad, output dt_t dt);
		int k;
		dt = dt_t'($urandom);
		if (keys.size() == 0 || $urandom_range(1, 0) == 1) begin
			op = OP_WRITE;
			nb = nb_t'($urandom_range(MEM_SEGS - 1, 0));
			ad = ad_t'($urandom_range(SEG_WORDS - 1, 0));
		end else begin
			op = OP_READ;
			k = keys[$urandom_range(keys.size() - 1, 0)];
			nb = nb_t'(k >> AD_W);
			ad = ad_t'(k);
		end
	endtask

	// expected read word, model write
	task automatic model_step(input bus_op_e op, input nb_t nb, input ad_t ad, input dt_t dt,
			output dt_t exp);
		int k;
		k = key_of(nb, ad);
		exp = '0;
		// absent segments hold nothing
		if (int'(nb) < MEM_SEGS) begin
			if (op == OP_READ) begin
				exp = model[k];
			end else begin
				if (!model.exists(k)) begin
					keys.push_back(k);
				end
				model[k] = dt;
			end
		end
	endtask

	// one isolated access, checked end to end
	task automatic access(input bit sel, input bus_op_e op, input nb_t nb, input ad_t ad,
			input dt_t dt, input string name);
		dt_t exp;
		bit miss;
		int n;
		miss = (int'(nb) >= MEM_SEGS);
		model_step(op, nb, ad, dt, exp);
		drive_cmd(sel, 1'b1, op, nb, ad, dt);
		next_cycle();
		drive_cmd(sel, 1'b0, op, nb, ad, dt);
		n = 0;
		while (!(sel ? io_done : cpu_done)) begin
			next_cycle();
			n++;
		end
		check({name, " err"}, 32'(miss), 32'(sel ? io_err : cpu_err));
		check({name, " alarm"}, 32'(miss), 32'(alarm));
		// busy still up on the done cycle
		check({name, " busy"}, 1, 32'(sel ? io_busy : cpu_busy));
		if (miss || op == OP_READ) begin
			check({name, " rdata"}, 32'(exp), 32'(sel ? io_rdata : cpu_rdata));
		end
		// zg, zw, strobe, ok
		if (!miss) begin
			check({name, " latency"}, 4, n);
		end
		next_cycle();
		check({name, " busy"}, 0, 32'(sel ? io_busy : cpu_busy));
	endtask

	// ----------------------------------------------------------
	// tests
	// ----------------------------------------------------------

	task automatic power_on();
		int n;
		check("reset pon", 0, 32'(pon));
		check("reset busy", 0, 32'(cpu_busy | io_busy));
		rst_n = 1'b1;
		// command while cl still holds the bus
		drive_cmd(1'b0, 1'b1, OP_WRITE, '0, '0, 16'h1234);
		n = 0;
		while (!pon) begin
			next_cycle();
			cpu_req = 1'b0;
			n++;
			check("early cmd", 0, 32'(cpu_done | cpu_busy));
		end
		check("pon delay", CLEAR_TICKS, n);
		repeat (8) begin
			next_cycle();
			check("early cmd", 0, 32'(cpu_done | cpu_busy));
		end
	endtask

	task automatic run_random(input bit sel, input string name);
		bus_op_e op;
		nb_t nb;
		ad_t ad;
		dt_t dt;
		for (int i = 0; i < RAND_N; i++) begin
			rand_cmd(op, nb, ad, dt);
			access(sel, op, nb, ad, dt, name);
		end
	endtask

	// both masters in the same cycle, cpu has priority
	task automatic arbitrate();
		bus_op_e c_op, i_op;
		nb_t c_nb, i_nb;
		ad_t c_ad, i_ad;
		dt_t c_dt, i_dt;
		dt_t c_exp, i_exp;
		dt_t c_got, i_got;
		int n, c_n, i_n;
		for (int i = 0; i < ARB_N; i++) begin
			rand_cmd(c_op, c_nb, c_ad, c_dt);
			rand_cmd(i_op, i_nb, i_ad, i_dt);
			// cpu lands first in memory
			model_step(c_op, c_nb, c_ad, c_dt, c_exp);
			model_step(i_op, i_nb, i_ad, i_dt, i_exp);
			drive_cmd(1'b0, 1'b1, c_op, c_nb, c_ad, c_dt);
			drive_cmd(1'b1, 1'b1, i_op, i_nb, i_ad, i_dt);
			next_cycle();
			cpu_req = 1'b0;
			io_req = 1'b0;
			n = 0;
			c_n = 0;
			i_n = 0;
			while (c_n == 0 || i_n == 0) begin
				next_cycle();
				n++;
				if (cpu_done) begin
					c_n = n;
					c_got = cpu_rdata;
					check("arb cpu err", 0, 32'(cpu_err));
				end
				if (io_done) begin
					i_n = n;
					i_got = io_rdata;
					check("arb io err", 0, 32'(io_err));
				end
			end
			next_cycle();
			check("arb cpu latency", 4, c_n);
			check("arb order", 1, 32'(c_n < i_n));
			if (c_op == OP_READ) begin
				check("arb cpu rdata", 32'(c_exp), 32'(c_got));
			end
			if (i_op == OP_READ) begin
				check("arb io rdata", 32'(i_exp), 32'(i_got));
			end
		end
	endtask

	// segments at or above MEM_SEGS never answer
	task automatic missing();
		bus_op_e op;
		nb_t nb;
		int k;
		for (int i = 0; i < MISS_N; i++) begin
			nb = nb_t'($urandom_range(15, MEM_SEGS));
			op = ($urandom_range(1, 0) == 1) ? OP_WRITE : OP_READ;
			// same word offset as a known present word
			k = keys[$urandom_range(keys.size() - 1, 0)];
			access(i % 2 == 1, op, nb, ad_t'(k), dt_t'($urandom), "missing");
			// present word left as the model has it
			access(i % 2 == 0, OP_READ, nb_t'(k >> AD_W), ad_t'(k), '0, "missing readback");
		end
	endtask

	task automatic op_clear();
		int k;
		clear_req = 1'b1;
		next_cycle();
		clear_req = 1'b0;
		// pon rides through the cl pulse
		for (int i = 0; i < CLEAR_TICKS + 2; i++) begin
			check("clear pon", 1, 32'(pon));
			next_cycle();
		end
		for (int i = 0; i < CLR_N; i++) begin
			k = keys[$urandom_range(keys.size() - 1, 0)];
			access(i % 2 == 1, OP_READ, nb_t'(k >> AD_W), ad_t'(k), '0, "clear readback");
		end
	endtask

	// ----------------------------------------------------------
	// sequence
	// ----------------------------------------------------------

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		clear_req = 1'b0;
		drive_cmd(1'b0, 1'b0, OP_READ, '0, '0, '0);
		drive_cmd(1'b1, 1'b0, OP_READ, '0, '0, '0);
		repeat (5) next_cycle();
		power_on();
		run_random(1'b0, "cpu random");
		run_random(1'b1, "io random");
		arbitrate();
		missing();
		op_clear();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* hw/m400_sys.sv */
`timescale 1ns/1ps

module m400_sys #(
	parameter int MEM_SEGS    = 2,
	parameter int SEG_WORDS   = 256,
	parameter int NOMEM_TICKS = 16,
	parameter int CLEAR_TICKS = 8
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              clear_req,
	output logic              pon,
	output logic              alarm,
	// cpu side requester
	input  logic              cpu_req,
	input  m400_pkg::bus_op_e cpu_op,
	input  m400_pkg::nb_t     cpu_nb,
	input  m400_pkg::ad_t     cpu_ad,
	input  m400_pkg::dt_t     cpu_dt,
	output logic              cpu_busy,
	output logic              cpu_done,
	output logic              cpu_err,
	output m400_pkg::dt_t     cpu_rdata,
	// io bridge requester
	input  logic              io_req,
	input  m400_pkg::bus_op_e io_op,
	input  m400_pkg::nb_t     io_nb,
	input  m400_pkg::ad_t     io_ad,
	input  m400_pkg::dt_t     io_dt,
	output logic              io_busy,
	output logic              io_done,
	output logic              io_err,
	output m400_pkg::dt_t     io_rdata
);

	// ----------------------------------------------------------
	// system bus
	// ----------------------------------------------------------

	sysbus_if bus_cpu ();
	sysbus_if bus_io ();
	sysbus_if bus_mem ();

	// reservation, bit 0 cpu, bit 1 io
	logic [1:0] zg;
	logic [1:0] zw;
	logic [1:0] zz;
	logic cl;

	isk u_isk (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.cl_in(cl),
		.zg(zg),
		.zz(zz),
		.zw(zw),
		.cpu(bus_cpu.arb),
		.io(bus_io.arb),
		.mem(bus_mem.hub)
	);

	// ----------------------------------------------------------
	// requesters
	// ----------------------------------------------------------

	bus_master #(
		.NOMEM_TICKS(NOMEM_TICKS)
	) u_cpu0 (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.pon(pon),
		.cmd_req(cpu_req),
		.cmd_op(cpu_op),
		.cmd_nb(cpu_nb),
		.cmd_ad(cpu_ad),
		.cmd_dt(cpu_dt),
		.busy(cpu_busy),
		.done(cpu_done),
		.err(cpu_err),
		.rdata(cpu_rdata),
		.zg(zg[0]),
		.zw(zw[0]),
		.zz(zz[0]),
		.bus(bus_cpu.master)
	);

	bus_master #(
		.NOMEM_TICKS(NOMEM_TICKS)
	) u_iob (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.pon(pon),
		.cmd_req(io_req),
		.cmd_op(io_op),
		.cmd_nb(io_nb),
		.cmd_ad(io_ad),
		.cmd_dt(io_dt),
		.busy(io_busy),
		.done(io_done),
		.err(io_err),
		.rdata(io_rdata),
		.zg(zg[1]),
		.zw(zw[1]),
		.zz(zz[1]),
		.bus(bus_io.master)
	);

	// ----------------------------------------------------------
	// memory and power
	// ----------------------------------------------------------

	mem_seg #(
		.MEM_SEGS(MEM_SEGS),
		.SEG_WORDS(SEG_WORDS)
	) u_mem (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.bus(bus_mem.mem)
	);

	puks #(
		.CLEAR_TICKS(CLEAR_TICKS)
	) u_puks (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.clear_req(clear_req),
		.cl(cl),
		.pon(pon)
	);

	// no-memory from either requester
	assign alarm = cpu_err | io_err;

endmodule

/* hw/mem_seg.sv */
`timescale 1ns/1ps

module mem_seg #(
	parameter int MEM_SEGS  = 2,
	parameter int SEG_WORDS = 256
) (
	input  logic  clk_sys,
	input  logic  rst_n,
	sysbus_if.mem bus
);
	import m400_pkg::*;

	localparam int DEPTH = MEM_SEGS * SEG_WORDS;
	// modelled address bits within a segment
	localparam int AW = $clog2(SEG_WORDS);
	localparam int IW = $clog2(DEPTH);

	// all present segments back to back
	dt_t words [DEPTH];

	logic [IW-1:0] idx;
	logic strobe;
	logic present;
	logic ok_q;
	dt_t rdt_q;

	assign strobe = bus.w || bus.r;
	// absent segments never answer
	assign present = (int'(bus.nb) < MEM_SEGS);
	// segment base plus word offset
	assign idx = IW'(int'(bus.nb) * SEG_WORDS + int'(bus.ad[AW-1:0]));

	// ----------------------------------------------------------
	// answer
	// ----------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n || bus.cl) begin
			ok_q <= 1'b0;
		end else begin
			ok_q <= strobe && present;
		end
	end

	// ok falls with the strobe
	assign bus.ok = ok_q && strobe;

	// ----------------------------------------------------------
	// array access
	// ----------------------------------------------------------

	// once per strobe, on the edge that raises ok
	always_ff @(posedge clk_sys) begin
		if (bus.w && present && !ok_q) begin
			words[idx] <= bus.dt;
		end
		if (bus.r && present && !ok_q) begin
			rdt_q <= words[idx];
		end
	end

	// read word valid with ok
	assign bus.rdt = rdt_q;

	// ok only inside a strobe that was already up a cycle earlier
	a_ok_in_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bus.ok |-> strobe && $past(strobe));

endmodule

/* hw/bus_master.sv */
`timescale 1ns/1ps

module bus_master #(
	parameter int NOMEM_TICKS = 16
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              pon,
	input  logic              cmd_req,
	input  m400_pkg::bus_op_e cmd_op,
	input  m400_pkg::nb_t     cmd_nb,
	input  m400_pkg::ad_t     cmd_ad,
	input  m400_pkg::dt_t     cmd_dt,
	output logic              busy,
	output logic              done,
	output logic              err,
	output m400_pkg::dt_t     rdata,
	output logic              zg,
	input  logic              zw,
	output logic              zz,
	sysbus_if.master          bus
);
	import m400_pkg::*;

	localparam int TW = $clog2(NOMEM_TICKS + 1);

	typedef enum logic [1:0] {
		MS_IDLE,
		MS_REQ,
		MS_CYCLE,
		MS_DONE
	} ms_e;

	ms_e state;
	logic [TW-1:0] tick;
	logic timeout;
	logic err_q;

	// latched command
	bus_op_e op_q;
	nb_t nb_q;
	ad_t ad_q;
	dt_t dt_q;

	// no ok within the window
	assign timeout = (tick == TW'(NOMEM_TICKS - 1)) && !bus.ok;

	// ----------------------------------------------------------
	// sequencing
	// ----------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		// cl drops the cycle with no done
		if (!rst_n || bus.cl) begin
			state <= MS_IDLE;
			tick <= '0;
		end else begin
			case (state)
				MS_IDLE: begin
					if (cmd_req && pon) begin
						state <= MS_REQ;
					end
				end
				MS_REQ: begin
					tick <= '0;
					if (zw) begin
						state <= MS_CYCLE;
					end
				end
				MS_CYCLE: begin
					tick <= tick + 1'b1;
					if (bus.ok || timeout) begin
						state <= MS_DONE;
					end
				end
				default: begin
					state <= MS_IDLE;
				end
			endcase
		end
	end

	// command capture and result
	always_ff @(posedge clk_sys) begin
		if (state == MS_IDLE && cmd_req && pon) begin
			op_q <= cmd_op;
			nb_q <= cmd_nb;
			ad_q <= cmd_ad;
			dt_q <= cmd_dt;
		end
		if (state == MS_CYCLE && bus.ok) begin
			err_q <= 1'b0;
			rdata <= (op_q == OP_READ) ? bus.rdt : '0;
		end else if (state == MS_CYCLE && timeout) begin
			err_q <= 1'b1;
			rdata <= '0;
		end
	end

	// ----------------------------------------------------------
	// outputs
	// ----------------------------------------------------------

	assign busy = (state != MS_IDLE);
	assign zg = (state == MS_REQ);
	assign done = (state == MS_DONE);
	// release together with done
	assign zz = (state == MS_DONE);
	assign err = (state == MS_DONE) && err_q;

	// strobe held for the whole cycle state
	assign bus.w = (state == MS_CYCLE) && (op_q == OP_WRITE);
	assign bus.r = (state == MS_CYCLE) && (op_q == OP_READ);
	assign bus.nb = nb_q;
	assign bus.ad = ad_q;
	assign bus.dt = dt_q;

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(bus.w && bus.r));

	// strobe only under a grant from isk
	a_strobe_granted: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(bus.w || bus.r) |-> zw);

endmodule

/* hw/puks.sv */
`timescale 1ns/1ps

module puks #(
	parameter int CLEAR_TICKS = 8
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic clear_req,
	output logic cl,
	output logic pon
);

	localparam int CW = $clog2(CLEAR_TICKS + 1);

	// power-on clear, running, operator clear
	typedef enum logic [1:0] {
		PS_CLEAR,
		PS_ON,
		PS_OPCLR
	} ps_e;

	ps_e state;
	logic [CW-1:0] tick;
	logic last_tick;

	// cl length reached
	assign last_tick = (tick == CW'(CLEAR_TICKS - 1));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= PS_CLEAR;
			tick <= '0;
		end else begin
			case (state)
				PS_CLEAR: begin
					if (last_tick) begin
						state <= PS_ON;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				PS_ON: begin
					// operator clear restarts the count
					if (clear_req) begin
						state <= PS_OPCLR;
						tick <= '0;
					end
				end
				PS_OPCLR: begin
					if (last_tick) begin
						state <= PS_ON;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				default: begin
					state <= PS_CLEAR;
					tick <= '0;
				end
			endcase
		end
	end

	// only source of cl in the system
	assign cl = (state != PS_ON);
	// power stays good through an operator clear
	assign pon = (state != PS_CLEAR);

endmodule

/* hw/isk.sv */
`timescale 1ns/1ps

module isk (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       cl_in,
	input  logic [1:0] zg,
	input  logic [1:0] zz,
	output logic [1:0] zw,
	sysbus_if.arb      cpu,
	sysbus_if.arb      io,
	sysbus_if.hub      mem
);

	// bit 0 cpu, bit 1 io, both low = bus free
	logic [1:0] gnt;

	// ----------------------------------------------------------
	// reservation
	// ----------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n || cl_in) begin
			gnt <= 2'b00;
		end else if (gnt == 2'b00) begin
			// cpu first
			if (zg[0]) begin
				gnt <= 2'b01;
			end else if (zg[1]) begin
				gnt <= 2'b10;
			end
		end else if ((zz & gnt) != 2'b00) begin
			// released by the owner, free next cycle
			gnt <= 2'b00;
		end
	end

	assign zw = gnt;

	// ----------------------------------------------------------
	// driver merge
	// ----------------------------------------------------------

	// clear goes everywhere
	assign mem.cl = cl_in;
	assign cpu.cl = cl_in;
	assign io.cl = cl_in;

	always_comb begin
		// idle bus when nobody holds it
		mem.w = 1'b0;
		mem.r = 1'b0;
		mem.nb = '0;
		mem.ad = '0;
		mem.dt = '0;
		if (gnt[0]) begin
			mem.w = cpu.w;
			mem.r = cpu.r;
			mem.nb = cpu.nb;
			mem.ad = cpu.ad;
			mem.dt = cpu.dt;
		end else if (gnt[1]) begin
			mem.w = io.w;
			mem.r = io.r;
			mem.nb = io.nb;
			mem.ad = io.ad;
			mem.dt = io.dt;
		end
	end

	// answer only to the owner
	assign cpu.ok = gnt[0] & mem.ok;
	assign cpu.rdt = gnt[0] ? mem.rdt : '0;
	assign io.ok = gnt[1] & mem.ok;
	assign io.rdt = gnt[1] ? mem.rdt : '0;

	// never two owners
	a_one_owner: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(zw[0] && zw[1]));

endmodule

/* hw/sysbus_if.sv */
`timescale 1ns/1ps

interface sysbus_if;
	import m400_pkg::*;

	// clear, forwarded from puks by isk
	logic cl;
	// write and read strobes
	logic w;
	logic r;
	// memory answer
	logic ok;
	// segment, address, write data
	nb_t nb;
	ad_t ad;
	dt_t dt;
	// read data back from memory
	dt_t rdt;

	// requester side
	modport master (output w, r, nb, ad, dt, input ok, rdt, cl);

	// isk side of a requester bundle
	modport arb (input w, r, nb, ad, dt, output ok, rdt, cl);

	// isk side of the memory bundle
	modport hub (output cl, w, r, nb, ad, dt, input ok, rdt);

	// memory side
	modport mem (input cl, w, r, nb, ad, dt, output ok, rdt);

endinterface

/* hw/m400_pkg.sv */
package m400_pkg;

	// ----------------------------------------------------------
	// system bus field widths
	// ----------------------------------------------------------

	// segment number (nb)
	localparam int NB_W = 4;

	// word address within a segment (ad)
	localparam int AD_W = 16;

	// data word (dt / rdt)
	localparam int DT_W = 16;

	// ----------------------------------------------------------
	// bus field types
	// ----------------------------------------------------------

	typedef logic [NB_W-1:0] nb_t;
	typedef logic [AD_W-1:0] ad_t;
	typedef logic [DT_W-1:0] dt_t;

	// ----------------------------------------------------------
	// master command operation
	// ----------------------------------------------------------

	// read raises r, write raises w
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} bus_op_e;

endpackage
